// ==== Bender.yml ====
package:
  name: packet_regroup

sources:
  - hdl/regroup_pkg.sv
  - hdl/packet_annotate.sv
  - hdl/word_compactor.sv
  - hdl/sop_regroup.sv
  - hdl/regroup_status_apb.sv
  - hdl/packet_regroup_top.sv
  - target: simulation
    files:
      - dv/regroup_checker.sv
      - dv/regroup_tb.sv

// ==== dv/regroup_checker.sv ====
`timescale 1ns/10ps

module regroup_checker (
	input  logic clk,
	input  logic reset,
	input  logic compare_en,
	input  logic [regroup_pkg::beat_len-1:0] avl_dout,
	input  logic avl_sop,
	input  logic avl_eop,
	input  logic [regroup_pkg::empty_len-1:0] avl_empty,
	input  logic avl_valid,
	input  logic avl_error,
	input  logic overflow
);
	import regroup_pkg::*;

	// data words of the packet being recorded
	logic [word_len-1:0] word_q [$];
	// expected beats in output order
	beat_t exp_q [$];
	int err_cnt = 0;
	int last_err = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	// overflow pulses seen on the output since reset
	int ovf_pulses = 0;

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// kind 0 is a normal packet, 1 a stray data word, 2 a packet cut by a new sop
	// beat idx covers words idx*4 up to the packet end, first word in the top lane
	function automatic beat_t ref_beat(int nbytes, int kind, int idx, int nwords);
		beat_t b;
		int first;
		int n;
		int spare;
		b = '0;
		first = idx * num_words;
		n = nwords - first;
		if (n > num_words)
			n = num_words;
		for (int k = 0; k < n; k++)
			b.data[(num_words-1-k)*word_len +: word_len] = word_q[first + k];
		// a stray word has no sop of its own
		b.sop = (idx == 0) && (kind != 1);
		b.eop = (first + n == nwords);
		b.error = (kind != 0);
		// unused bytes of the last word, a full word leaves none
		spare = (8 - nbytes % 8) % 8;
		if (b.eop)
			b.empty = empty_len'((num_words - n) * 8 + spare);
		return b;
	endfunction

	task automatic add_word(input logic [word_len-1:0] w);
		word_q.push_back(w);
	endtask

	// turn the recorded words into expected beats
	task automatic add_packet(input int nbytes, input int kind);
		int nw;
		nw = (nbytes + 7) / 8;
		for (int idx = 0; idx < (nw + num_words - 1) / num_words; idx++)
			exp_q.push_back(ref_beat(nbytes, kind, idx, nw));
		word_q.delete();
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	////////////////////////////////////////
	// comparison and reporting
	////////////////////////////////////////

	task automatic check_field(input string name, input logic [beat_len-1:0] exp,
		input logic [beat_len-1:0] act);
		if (exp !== act) begin
			err_cnt++;
			$display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	task automatic note_fail(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	// outputs are registered on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		beat_t e;
		if (!reset && avl_valid && compare_en) begin
			if (exp_q.size() == 0) begin
				note_fail($sformatf("beat at %0t ns arrived with none expected", $time));
			end else begin
				e = exp_q.pop_front();
				check_field("avl_dout", e.data, avl_dout);
				check_field("avl_sop", beat_len'(e.sop), beat_len'(avl_sop));
				check_field("avl_eop", beat_len'(e.eop), beat_len'(avl_eop));
				check_field("avl_empty", beat_len'(e.empty), beat_len'(avl_empty));
				check_field("avl_error", beat_len'(e.error), beat_len'(avl_error));
			end
		end
	end

	// each high cycle is one dropped arrival
	always @(negedge clk) begin
		if (!reset && overflow)
			ovf_pulses++;
	end

	// one line per test, errors since the previous test
	task automatic end_test(input string name);
		if (err_cnt == last_err) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_cnt - last_err);
		end
		last_err = err_cnt;
	endtask

	task automatic report_summary();
		$display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
	endtask

endmodule

// ==== dv/regroup_tb.sv ====
`timescale 1ns/10ps

module regroup_tb;
	import regroup_pkg::*;

	logic clk;
	logic reset;
	lane_word_t [num_words-1:0] din;
	logic [cnt_len-1:0] num_din_valid;
	logic [beat_len-1:0] avl_dout;
	logic avl_sop;
	logic avl_eop;
	logic [empty_len-1:0] avl_empty;
	logic avl_valid;
	logic avl_error;
	logic overflow;
	reg_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_data_len-1:0] pwdata;
	logic [apb_data_len-1:0] prdata;
	logic pready;
	logic pslverr;
	logic compare_en;

	integer seed;
	// lane words still to be sent, oldest first
	lane_word_t lane_q [$];
	// record packets in the checker only while beats are compared
	bit track;
	int stim_cycles = 0;
	int cycle_cnt = 0;
	int pkt_total = 0;
	logic [apb_data_len-1:0] rd;
	logic rd_err;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	packet_regroup_top i_dut (
		.clk(clk), .reset(reset), .din(din), .num_din_valid(num_din_valid),
		.avl_dout(avl_dout), .avl_sop(avl_sop), .avl_eop(avl_eop), .avl_empty(avl_empty),
		.avl_valid(avl_valid), .avl_error(avl_error), .overflow(overflow),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	regroup_checker i_checker (
		.clk(clk), .reset(reset), .compare_en(compare_en), .avl_dout(avl_dout),
		.avl_sop(avl_sop), .avl_eop(avl_eop), .avl_empty(avl_empty),
		.avl_valid(avl_valid), .avl_error(avl_error), .overflow(overflow)
	);

	// watchdog grows with the stimulus already sent
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > 10 * stim_cycles + 200) begin
			$display("timeout after %0d cycles, the DUT stopped producing beats", cycle_cnt);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////
	// packet to lane encoder
	////////////////////////////////////////

	function automatic int rand_range(int lo, int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// kind in bits 63:62, eop at 60, byte count in 59:57
	function automatic lane_word_t ctrl_word(logic [1:0] kind, logic eop, logic [2:0] bytes);
		lane_word_t w;
		w.ctrl = 1'b1;
		w.payload = {kind, 1'b0, eop, bytes, 57'h0};
		return w;
	endfunction

	// first byte in the top bits, unused low bytes zero
	task automatic push_data(input int nb);
		lane_word_t w;
		logic [word_len-1:0] d;
		d = {$random(seed), $random(seed)};
		if (nb < 8)
			d = d & ~({word_len{1'b1}} >> (nb * 8));
		w.ctrl = 1'b0;
		w.payload = d;
		lane_q.push_back(w);
		if (track)
			i_checker.add_word(d);
	endtask

	// kind 1 drops the sop control word, kind 2 drops the eop control word
	task automatic queue_packet(input int nbytes, input int kind);
		int nw;
		int rem;
		nw = (nbytes + 7) / 8;
		rem = nbytes;
		if (kind != 1)
			lane_q.push_back(ctrl_word(ctrl_burst_sop, 1'b0, 3'd0));
		for (int i = 0; i < nw; i++) begin
			push_data(rem > 8 ? 8 : rem);
			rem -= 8;
		end
		if (kind != 2)
			lane_q.push_back(ctrl_word(ctrl_burst, 1'b1, 3'(nbytes % 8)));
		if (track)
			i_checker.add_packet(nbytes, kind);
	endtask

	// earliest word goes to the top lane
	task automatic send_stream(input bit full);
		int n;
		while (lane_q.size() != 0) begin
			@(negedge clk);
			n = full ? num_words : rand_range(0, num_words);
			if (n > lane_q.size())
				n = lane_q.size();
			din = '0;
			for (int k = 0; k < n; k++)
				din[num_words-1-k] = lane_q.pop_front();
			num_din_valid = cnt_len'(n);
			stim_cycles++;
		end
		@(negedge clk);
		din = '0;
		num_din_valid = '0;
	endtask

	task automatic wait_drain();
		while (i_checker.pending() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	////////////////////////////////////////
	// APB access
	////////////////////////////////////////

	task automatic apb_read(input reg_addr_t a, output logic [apb_data_len-1:0] d,
		output logic err);
		@(negedge clk);
		paddr = a;
		pwrite = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		// mid access phase
		#10;
		d = prdata;
		err = pslverr;
		if (pready !== 1'b1)
			i_checker.note_fail("pready low in the access phase of a read");
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		stim_cycles += 3;
	endtask

	task automatic apb_write(input reg_addr_t a, input logic [apb_data_len-1:0] d);
		@(negedge clk);
		paddr = a;
		pwdata = d;
		pwrite = 1'b1;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		#10;
		if (pready !== 1'b1)
			i_checker.note_fail("pready low in the access phase of a write");
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		stim_cycles += 3;
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		int lens [7];
		lens = '{1, 8, 9, 31, 32, 33, 40};
		seed = 32'haad7;
		reset = 1'b1;
		din = '0;
		num_din_valid = '0;
		paddr = reg_packet_count;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		compare_en = 1'b1;
		track = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// one packet at a time, full lanes
		foreach (lens[i]) begin
			queue_packet(lens[i], 0);
			send_stream(1'b1);
			wait_drain();
			pkt_total++;
		end
		i_checker.end_test("single packets");

		// random lengths and lane fill, idle cycles included
		for (int i = 0; i < 30; i++)
			queue_packet(rand_range(1, 40), 0);
		pkt_total += 30;
		send_stream(1'b0);
		wait_drain();
		i_checker.end_test("random fill");

		// eop and next sop share a cycle
		for (int i = 0; i < 12; i++)
			queue_packet(rand_range(17, 32), 0);
		pkt_total += 12;
		send_stream(1'b1);
		wait_drain();
		i_checker.end_test("back to back");

		// counters over APB
		apb_read(reg_packet_count, rd, rd_err);
		i_checker.check_field("packet count", beat_len'(pkt_total), beat_len'(rd));
		if (rd_err)
			i_checker.note_fail("pslverr raised on a mapped address");
		apb_write(reg_clear, 32'h1);
		apb_read(reg_packet_count, rd, rd_err);
		i_checker.check_field("cleared packet count", '0, beat_len'(rd));
		apb_read(reg_addr_t'(8'h10), rd, rd_err);
		if (!rd_err)
			i_checker.note_fail("unmapped address read without pslverr");
		i_checker.end_test("apb status");

		// stray data words and sop inside an open packet
		apb_write(reg_clear, 32'h2);
		for (int i = 0; i < 3; i++) begin
			queue_packet(rand_range(1, 40), 0);
			queue_packet(rand_range(1, 8), 1);
			queue_packet(8 * rand_range(1, 3), 2);
			queue_packet(rand_range(1, 40), 0);
		end
		send_stream(1'b0);
		wait_drain();
		apb_read(reg_error_count, rd, rd_err);
		i_checker.check_field("error count", beat_len'(6), beat_len'(rd));
		i_checker.end_test("error injection");

		// one-word packets faster than one beat per cycle
		track = 1'b0;
		compare_en = 1'b0;
		for (int i = 0; i < 60; i++)
			queue_packet(1, 0);
		send_stream(1'b1);
		repeat (20) @(negedge clk);
		stim_cycles += 20;
		apb_read(reg_overflow_count, rd, rd_err);
		if (i_checker.ovf_pulses == 0)
			i_checker.note_fail("overflow output never pulsed during the one-word burst");
		i_checker.check_field("overflow count", beat_len'(i_checker.ovf_pulses),
			beat_len'(rd));
		i_checker.end_test("overflow");

		i_checker.report_summary();
		if (i_checker.tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== hdl/packet_annotate.sv ====
`timescale 1ns/10ps

module packet_annotate (
	input  logic clk,
	input  logic reset,
	input  regroup_pkg::lane_word_t [regroup_pkg::num_words-1:0] din,
	input  logic [regroup_pkg::cnt_len-1:0] num_din_valid,
	output regroup_pkg::annot_word_t [regroup_pkg::num_words-1:0] dout,
	output logic [regroup_pkg::num_words-1:0] dout_valid
);
	import regroup_pkg::*;

	// per lane flags, lane 3 is the top lane
	logic [num_words-1:0] lane_used;
	logic [num_words-1:0] lane_last;
	logic [num_words-1:0] lane_data;
	eop_info_t [num_words-1:0] ctrl_info;
	annot_word_t [num_words-1:0] lane_annot;
	logic sop_pend;
	logic sop_pend_nxt;

	// last data word seen, waiting for the word after it
	annot_word_t held_word;
	logic held_valid;

	annot_word_t [num_words-1:0] emit_word;
	logic [num_words-1:0] emit_valid;

	always_comb begin
		for (int i = 0; i < num_words; i++) begin
			// valid words fill the lanes from the top down
			lane_used[i] = (num_words - i) <= num_din_valid;
			lane_data[i] = lane_used[i] && !din[i].ctrl;
			ctrl_info[i] = (lane_used[i] && din[i].ctrl) ? ctrl_eop(din[i]) : '0;
		end
		// lowest lane in use has no successor this cycle
		lane_last = lane_used & ~(lane_used << 1);
	end

	// walk lanes from the top, carrying a pending SOP
	always_comb begin
		logic pend;
		pend = sop_pend;
		for (int i = num_words - 1; i >= 0; i--) begin
			lane_annot[i].data = din[i].payload;
			lane_annot[i].sop = lane_data[i] && pend;
			if (lane_used[i] && din[i].ctrl && ctrl_kind(din[i]) == ctrl_burst_sop)
				pend = 1'b1;
			else if (lane_data[i])
				pend = 1'b0;
		end
		sop_pend_nxt = pend;
		// eop rides on the control word right below a data word
		lane_annot[0].eop = '0;
		for (int i = 1; i < num_words; i++)
			lane_annot[i].eop = ctrl_info[i-1];
	end

	// held word leaves from the top slot once anything arrives
	// lane i moves down to slot i-1 so the order is kept
	always_comb begin
		emit_word[num_words-1] = held_word;
		emit_word[num_words-1].eop = ctrl_info[num_words-1];
		emit_valid[num_words-1] = held_valid && lane_used[num_words-1];
		for (int i = 1; i < num_words; i++) begin
			emit_word[i-1] = lane_annot[i];
			emit_valid[i-1] = lane_data[i] && lane_used[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			dout_valid <= '0;
			held_valid <= 1'b0;
			sop_pend <= 1'b0;
		end else begin
			dout_valid <= emit_valid;
			sop_pend <= sop_pend_nxt;
			if (num_din_valid != '0)
				held_valid <= |(lane_last & lane_data);
		end
	end

	always_ff @(posedge clk) begin
		dout <= emit_word;
		for (int i = 0; i < num_words; i++)
			if (lane_last[i] && lane_data[i])
				held_word <= lane_annot[i];
	end

	a_din_count: assert property (@(posedge clk) disable iff (reset)
		num_din_valid <= num_words)
		else $error("num_din_valid above lane count");

endmodule

// ==== hdl/packet_regroup_top.sv ====
`timescale 1ns/10ps

module packet_regroup_top (
	input  logic clk,
	input  logic reset,
	input  regroup_pkg::lane_word_t [regroup_pkg::num_words-1:0] din,
	input  logic [regroup_pkg::cnt_len-1:0] num_din_valid,
	output logic [regroup_pkg::beat_len-1:0] avl_dout,
	output logic avl_sop,
	output logic avl_eop,
	output logic [regroup_pkg::empty_len-1:0] avl_empty,
	output logic avl_valid,
	output logic avl_error,
	output logic overflow,
	input  regroup_pkg::reg_addr_t paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [regroup_pkg::apb_data_len-1:0] pwdata,
	output logic [regroup_pkg::apb_data_len-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import regroup_pkg::*;

	annot_word_t [num_words-1:0] annot_words;
	logic [num_words-1:0] annot_valid;
	annot_word_t [num_words-1:0] compact_words;
	logic [cnt_len-1:0] compact_num;
	beat_t beat;
	logic packet_done;
	logic error_seen;

	////////////////////////////////////////
	// data path
	////////////////////////////////////////

	// strip control words, tag sop and eop
	packet_annotate i_annotate (
		.clk(clk),
		.reset(reset),
		.din(din),
		.num_din_valid(num_din_valid),
		.dout(annot_words),
		.dout_valid(annot_valid)
	);

	// close the gaps left by control words
	word_compactor i_compact (
		.clk(clk),
		.reset(reset),
		.din(annot_words),
		.din_valid(annot_valid),
		.dout(compact_words),
		.num_dout_valid(compact_num)
	);

	// sop aligned beats
	sop_regroup i_regroup (
		.clk(clk),
		.reset(reset),
		.din(compact_words),
		.din_num_valid(compact_num),
		.beat(beat),
		.beat_valid(avl_valid),
		.overflow(overflow),
		.packet_done(packet_done),
		.error_seen(error_seen)
	);

	assign avl_dout = beat.data;
	assign avl_sop = beat.sop;
	assign avl_eop = beat.eop;
	assign avl_empty = beat.empty;
	assign avl_error = beat.error;

	////////////////////////////////////////
	// status counters
	////////////////////////////////////////

	regroup_status_apb i_status (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.packet_done(packet_done),
		.error_seen(error_seen),
		.overflow_seen(overflow)
	);

endmodule

// ==== hdl/regroup_pkg.sv ====
package regroup_pkg;

	////////////////////////////////////////
	// lane and buffer geometry
	////////////////////////////////////////

	// four lane words per cycle, 64 data bits each
	localparam int num_words = 4;
	localparam int word_len = 64;
	// width of a 0..4 word count
	localparam int cnt_len = 3;
	// regroup queue depth and its 0..8 occupancy count
	localparam int buf_words = 8;
	localparam int qcnt_len = 4;
	// output beat payload and empty byte count
	localparam int beat_len = num_words * word_len;
	localparam int empty_len = 5;

	// control word field positions inside the 64 payload bits
	// bit 63 is burst versus idle and bit 62 flags SOP
	localparam int ctrl_kind_lo = 62;
	// eop flag at bit 60, valid byte count in bits 59:57
	localparam int eop_info_lo = 57;

	// status block widths and clear register bit positions
	localparam int count_len = 16;
	localparam int apb_addr_len = 8;
	localparam int apb_data_len = 32;
	localparam int clr_packet_bit = 0;
	localparam int clr_error_bit = 1;
	localparam int clr_overflow_bit = 2;

	////////////////////////////////////////
	// word formats
	////////////////////////////////////////

	typedef struct packed {
		logic ctrl;
		logic [word_len-1:0] payload;
	} lane_word_t;

	typedef enum logic [1:0] {
		ctrl_idle = 2'b00,
		ctrl_burst = 2'b10,
		ctrl_burst_sop = 2'b11
	} ctrl_kind_t;

	// bytes of zero means all eight bytes are valid
	typedef struct packed {
		logic eop;
		logic [2:0] bytes;
	} eop_info_t;

	typedef struct packed {
		logic sop;
		eop_info_t eop;
		logic [word_len-1:0] data;
	} annot_word_t;

	// data lane 3 sits in bits 255:192
	typedef struct packed {
		logic [beat_len-1:0] data;
		logic sop;
		logic eop;
		logic [empty_len-1:0] empty;
		logic error;
	} beat_t;

	typedef enum logic [apb_addr_len-1:0] {
		reg_packet_count = 8'h00,
		reg_error_count = 8'h04,
		reg_overflow_count = 8'h08,
		reg_clear = 8'h0c
	} reg_addr_t;

	// field extraction from a control word
	function automatic ctrl_kind_t ctrl_kind(lane_word_t w);
		return ctrl_kind_t'(w.payload[ctrl_kind_lo +: 2]);
	endfunction

	function automatic eop_info_t ctrl_eop(lane_word_t w);
		return eop_info_t'(w.payload[eop_info_lo +: 4]);
	endfunction

endpackage

// ==== hdl/regroup_status_apb.sv ====
`timescale 1ns/10ps

module regroup_status_apb (
	input  logic clk,
	input  logic reset,
	input  regroup_pkg::reg_addr_t paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [regroup_pkg::apb_data_len-1:0] pwdata,
	output logic [regroup_pkg::apb_data_len-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic packet_done,
	input  logic error_seen,
	input  logic overflow_seen
);
	import regroup_pkg::*;

	logic [count_len-1:0] packet_count;
	logic [count_len-1:0] error_count;
	logic [count_len-1:0] overflow_count;
	logic clr_write;
	logic [2:0] clr_mask;

	// saturating increment, a clear wins over a same cycle event
	function automatic logic [count_len-1:0] count_next(
		input logic [count_len-1:0] cur,
		input logic inc,
		input logic clr
	);
		if (clr)
			return '0;
		if (inc && cur != '1)
			return cur + 1'b1;
		return cur;
	endfunction

	// write takes effect in the access phase
	assign clr_write = psel && penable && pwrite && paddr == reg_clear;
	assign clr_mask = clr_write ? pwdata[2:0] : 3'b000;

	always_ff @(posedge clk) begin
		if (reset) begin
			packet_count <= '0;
			error_count <= '0;
			overflow_count <= '0;
		end else begin
			packet_count <= count_next(packet_count, packet_done, clr_mask[clr_packet_bit]);
			error_count <= count_next(error_count, error_seen, clr_mask[clr_error_bit]);
			overflow_count <= count_next(overflow_count, overflow_seen,
				clr_mask[clr_overflow_bit]);
		end
	end

	// zero wait states
	assign pready = 1'b1;

	// read mux, unmapped addresses flag an error in the access phase
	always_comb begin
		prdata = '0;
		pslverr = 1'b0;
		case (paddr)
			reg_packet_count: prdata = apb_data_len'(packet_count);
			reg_error_count: prdata = apb_data_len'(error_count);
			reg_overflow_count: prdata = apb_data_len'(overflow_count);
			reg_clear: prdata = '0;
			default: pslverr = psel && penable;
		endcase
	end

endmodule

// ==== hdl/sop_regroup.sv ====
`timescale 1ns/10ps

module sop_regroup (
	input  logic clk,
	input  logic reset,
	input  regroup_pkg::annot_word_t [regroup_pkg::num_words-1:0] din,
	input  logic [regroup_pkg::cnt_len-1:0] din_num_valid,
	output regroup_pkg::beat_t beat,
	output logic beat_valid,
	output logic overflow,
	output logic packet_done,
	output logic error_seen
);
	import regroup_pkg::*;

	// word queue, q[0] is the oldest word
	annot_word_t q [buf_words];
	annot_word_t q_nxt [buf_words];
	logic [qcnt_len-1:0] q_cnt;
	logic [qcnt_len-1:0] q_cnt_nxt;
	logic pkt_open;

	// front window decision
	logic found;
	logic [cnt_len-1:0] take_n;
	logic cut_eop;
	logic cut_err;
	logic beat_err;
	beat_t beat_nxt;

	// queue refill
	logic [qcnt_len-1:0] keep_n;
	logic [qcnt_len:0] fill;
	logic drop;

	////////////////////////////////////////
	// pick the words for the next beat
	////////////////////////////////////////

	// a beat ends at an eop word or before a new sop
	// a full beat without eop also needs the fifth word in view
	// so that an sop right behind it can still close it
	always_comb begin
		found = 1'b0;
		take_n = '0;
		cut_eop = 1'b0;
		cut_err = 1'b0;
		for (int k = 0; k <= num_words; k++) begin
			if (!found && k < q_cnt) begin
				if (k > 0 && q[k].sop) begin
					found = 1'b1;
					take_n = cnt_len'(k);
					cut_eop = 1'b1;
					cut_err = 1'b1;
				end else if (k == num_words) begin
					found = 1'b1;
					take_n = cnt_len'(num_words);
				end else if (q[k].eop.eop) begin
					found = 1'b1;
					take_n = cnt_len'(k + 1);
					cut_eop = 1'b1;
				end
			end
		end
		// sop while open, or plain data while closed
		beat_err = cut_err || (q[0].sop == pkt_open);
	end

	// front word goes to the top lane
	always_comb begin
		eop_info_t last_info;
		logic [2:0] spare;
		logic [1:0] gap_lanes;
		last_info = '0;
		beat_nxt = '0;
		for (int k = 0; k < num_words; k++) begin
			if (k < take_n) begin
				beat_nxt.data[(num_words-1-k)*word_len +: word_len] = q[k].data;
				last_info = q[k].eop;
			end
		end
		// unused bytes of the last word, eight valid reads as zero
		spare = 3'd0;
		if (last_info.eop)
			spare = 3'd0 - last_info.bytes;
		gap_lanes = 2'(num_words - take_n);
		// an sop word may sit at the front while more words are awaited
		beat_nxt.sop = found && q[0].sop;
		beat_nxt.eop = cut_eop;
		beat_nxt.error = found && beat_err;
		if (cut_eop)
			beat_nxt.empty = {gap_lanes, spare};
	end

	////////////////////////////////////////
	// shift out the beat, append new words
	////////////////////////////////////////

	always_comb begin
		keep_n = q_cnt - qcnt_len'(take_n);
		fill = {1'b0, keep_n} + (qcnt_len+1)'(din_num_valid);
		// all incoming words are lost if they do not fit
		drop = (din_num_valid != '0) && (fill > buf_words);
		for (int i = 0; i < buf_words; i++) begin
			q_nxt[i] = q[i];
			if (i < keep_n)
				q_nxt[i] = q[i + take_n];
			else if (!drop && i < fill)
				q_nxt[i] = din[num_words - 1 - (i - keep_n)];
		end
		q_cnt_nxt = drop ? keep_n : fill[qcnt_len-1:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			q_cnt <= '0;
			pkt_open <= 1'b0;
			beat_valid <= 1'b0;
			overflow <= 1'b0;
			packet_done <= 1'b0;
			error_seen <= 1'b0;
			beat.sop <= 1'b0;
			beat.eop <= 1'b0;
			beat.error <= 1'b0;
		end else begin
			q_cnt <= q_cnt_nxt;
			if (found)
				pkt_open <= !cut_eop;
			beat_valid <= found;
			overflow <= drop;
			packet_done <= found && cut_eop;
			error_seen <= found && beat_err;
			beat <= beat_nxt;
		end
	end

	always_ff @(posedge clk) begin
		q <= q_nxt;
	end

	a_flags_need_valid: assert property (@(posedge clk) disable iff (reset)
		!beat_valid |-> !(beat.sop || beat.eop))
		else $error("beat flags set without beat_valid");

	a_queue_bound: assert property (@(posedge clk) disable iff (reset)
		q_cnt <= buf_words)
		else $error("regroup queue above capacity");

endmodule

// ==== hdl/word_compactor.sv ====
`timescale 1ns/10ps

module word_compactor (
	input  logic clk,
	input  logic reset,
	input  regroup_pkg::annot_word_t [regroup_pkg::num_words-1:0] din,
	input  logic [regroup_pkg::num_words-1:0] din_valid,
	output regroup_pkg::annot_word_t [regroup_pkg::num_words-1:0] dout,
	output logic [regroup_pkg::cnt_len-1:0] num_dout_valid
);
	import regroup_pkg::*;

	// number of valid words above each lane
	logic [cnt_len-1:0] rank [num_words];
	logic [cnt_len-1:0] pop_total;
	annot_word_t [num_words-1:0] packed_w;

	////////////////////////////////////////
	// running count from the top lane
	////////////////////////////////////////

	always_comb begin
		logic [cnt_len-1:0] run;
		run = '0;
		for (int i = num_words - 1; i >= 0; i--) begin
			rank[i] = run;
			run = run + cnt_len'(din_valid[i]);
		end
		pop_total = run;
	end

	////////////////////////////////////////
	// route each word to its packed slot
	////////////////////////////////////////

	// slot j takes the valid word with (3 - j) valid words above it
	// e.g. mask 1001 ends up as 1100
	always_comb begin
		for (int j = 0; j < num_words; j++) begin
			packed_w[j] = '0;
			for (int i = num_words - 1; i >= 0; i--) begin
				if (din_valid[i] && rank[i] == cnt_len'(num_words - 1 - j))
					packed_w[j] = din[i];
			end
		end
	end

	// one register stage, count cleared on reset
	always_ff @(posedge clk) begin
		if (reset)
			num_dout_valid <= '0;
		else
			num_dout_valid <= pop_total;
	end

	always_ff @(posedge clk) begin
		dout <= packed_w;
	end

endmodule

// ==== verilog.f ====
hdl/regroup_pkg.sv
hdl/packet_annotate.sv
hdl/word_compactor.sv
hdl/sop_regroup.sv
hdl/regroup_status_apb.sv
hdl/packet_regroup_top.sv
dv/regroup_checker.sv
dv/regroup_tb.sv
